/* common/sa_pkg.sv */
// systolic array shared definitions
package sa_pkg;

    localparam int DATA_W = 16;
    localparam int WORD_W = 32;
    localparam int ADDR_W = 8;
    localparam int KLEN_W = 5;
    localparam int AXI_AW = 12;

    // result area in the tile store
    localparam logic [ADDR_W-1:0] RES_BASE = 8'd128;

    // register map, byte offsets
    localparam logic [AXI_AW-1:0] REG_CTRL   = 12'h000;
    localparam logic [AXI_AW-1:0] REG_STATUS = 12'h004;
    localparam logic [AXI_AW-1:0] REG_KLEN   = 12'h008;
    localparam logic [AXI_AW-1:0] WIN_BASE   = 12'h400;

    // one store word, seen as an operand pair or as a tagged result
    typedef union packed {
        struct packed {
            logic [DATA_W-1:0] h_elem;
            logic [DATA_W-1:0] v_elem;
        } opnd;
        struct packed {
            logic [DATA_W-1:0] tag;
            logic [DATA_W-1:0] value;
        } res;
    } sa_word_u;

endpackage

/* pe_array/sa_pe.sv */
// multiply-accumulate processing element
`timescale 1ns/100ps

module sa_pe import sa_pkg::*; (
    input  logic              clk,
    input  logic              sys_rst,
    input  logic [1:0]        mode,
    input  logic              cal_en_n,
    input  logic              cal_done_n,
    input  logic [DATA_W-1:0] v_data_n,
    input  logic [DATA_W-1:0] h_data_w,
    input  logic              mulres_val_e,
    input  logic [DATA_W-1:0] mulres_e,
    output logic              cal_en_s,
    output logic              cal_done_s,
    output logic [DATA_W-1:0] v_data_s,
    output logic [DATA_W-1:0] h_data_e,
    output logic              mulres_val_w,
    output logic [DATA_W-1:0] mulres_w
);

    logic [1:0]        mode_q;
    logic              prod_vld;
    logic [DATA_W-1:0] product;
    logic [DATA_W-1:0] psum;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            cal_en_s     <= 1'b0;
            cal_done_s   <= 1'b0;
            mulres_val_w <= 1'b0;
            mode_q       <= 2'b00;
            prod_vld     <= 1'b0;
            psum         <= '0;
        end else begin
            cal_en_s     <= cal_en_n;
            cal_done_s   <= cal_done_n;
            mulres_val_w <= cal_done_n || mulres_val_e;
            mode_q       <= mode;
            prod_vld     <= cal_en_n;
            // new mode or finished sum starts from zero
            if (mode != mode_q || cal_done_n)
                psum <= '0;
            else if (prod_vld)
                psum <= psum + product;
        end
    end

    always_ff @(posedge clk) begin
        v_data_s <= v_data_n;
        h_data_e <= h_data_w;
        product  <= h_data_w * v_data_n;
        // own sum goes out on done, otherwise pass the eastern result
        if (cal_done_n)
            mulres_w <= psum + (prod_vld ? product : '0);
        else
            mulres_w <= mulres_e;
    end

    // skew keeps a neighbour's result one cycle clear of our own done
    a_no_res_collision: assert property (
        @(posedge clk) disable iff (sys_rst) !(mulres_val_e && cal_done_n)
    ) else $error("east result collides with cal_done");

endmodule

/* pe_array/sa_grid.sv */
// DIM x DIM processing element mesh
`timescale 1ns/100ps

module sa_grid import sa_pkg::*; #(
    parameter int DIM = 4
) (
    input  logic                  clk,
    input  logic                  sys_rst,
    input  logic [1:0]            mode,
    input  logic [DIM-1:0]        col_en,
    input  logic [DIM-1:0]        col_done,
    input  logic [DIM*DATA_W-1:0] col_data,
    input  logic [DIM*DATA_W-1:0] row_data,
    output logic [DIM-1:0]        row_res_val,
    output logic [DIM*DATA_W-1:0] row_res
);

    // north-south links, index [row][col], row DIM is the south edge
    logic              en_ns   [DIM+1][DIM];
    logic              done_ns [DIM+1][DIM];
    logic [DATA_W-1:0] v_ns    [DIM+1][DIM];
    // west-east links, index [row][col], col DIM is the east edge
    logic [DATA_W-1:0] h_we    [DIM][DIM+1];
    logic              val_ew  [DIM][DIM+1];
    logic [DATA_W-1:0] res_ew  [DIM][DIM+1];

    for (genvar j = 0; j < DIM; j++) begin : g_north
        assign en_ns[0][j]   = col_en[j];
        assign done_ns[0][j] = col_done[j];
        assign v_ns[0][j]    = col_data[j*DATA_W +: DATA_W];
    end

    for (genvar i = 0; i < DIM; i++) begin : g_row
        assign h_we[i][0]                 = row_data[i*DATA_W +: DATA_W];
        assign val_ew[i][DIM]             = 1'b0;
        assign res_ew[i][DIM]             = '0;
        assign row_res_val[i]             = val_ew[i][0];
        assign row_res[i*DATA_W +: DATA_W] = res_ew[i][0];

        for (genvar j = 0; j < DIM; j++) begin : g_col
            sa_pe i_pe (
                .clk          (clk),
                .sys_rst      (sys_rst),
                .mode         (mode),
                .cal_en_n     (en_ns[i][j]),
                .cal_done_n   (done_ns[i][j]),
                .v_data_n     (v_ns[i][j]),
                .h_data_w     (h_we[i][j]),
                .mulres_val_e (val_ew[i][j+1]),
                .mulres_e     (res_ew[i][j+1]),
                .cal_en_s     (en_ns[i+1][j]),
                .cal_done_s   (done_ns[i+1][j]),
                .v_data_s     (v_ns[i+1][j]),
                .h_data_e     (h_we[i][j+1]),
                .mulres_val_w (val_ew[i][j]),
                .mulres_w     (res_ew[i][j])
            );
        end
    end

endmodule

/* logic/operand_feeder.sv */
// operand fetch and skewed stream generator
`timescale 1ns/100ps

module operand_feeder import sa_pkg::*; #(
    parameter int DIM = 4
) (
    input  logic                  clk,
    input  logic                  sys_rst,
    input  logic                  start,
    input  logic [1:0]            mode,
    input  logic [KLEN_W-1:0]     k_len,
    input  logic                  gnt,
    input  logic [WORD_W-1:0]     rd_data,
    output logic                  req,
    output logic [ADDR_W-1:0]     addr,
    output logic                  busy,
    output logic [1:0]            grid_mode,
    output logic [DIM-1:0]        col_en,
    output logic [DIM-1:0]        col_done,
    output logic [DIM*DATA_W-1:0] col_data,
    output logic [DIM*DATA_W-1:0] row_data
);

    localparam int IDX_W  = (DIM > 1) ? $clog2(DIM) : 1;
    localparam int LANE_W = 2 + 2 * DATA_W;

    sa_word_u          word;
    logic              rd_act;
    logic              rd_vld;
    logic              base_en;
    logic              last_word;
    logic              last_step;
    logic [2:0]        fin_sr;
    logic [IDX_W-1:0]  w_cnt;
    logic [IDX_W-1:0]  rd_idx;
    logic [KLEN_W-1:0] k_cnt;
    logic [DATA_W-1:0] h_stg [DIM];
    logic [DATA_W-1:0] v_stg [DIM];

    assign word      = rd_data;
    assign req       = rd_act;
    assign addr      = ADDR_W'(k_cnt) * ADDR_W'(DIM) + ADDR_W'(w_cnt);
    assign last_word = (w_cnt == IDX_W'(DIM - 1));
    assign last_step = (k_cnt == k_len - 1'b1);

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            busy      <= 1'b0;
            rd_act    <= 1'b0;
            rd_vld    <= 1'b0;
            base_en   <= 1'b0;
            fin_sr    <= '0;
            w_cnt     <= '0;
            k_cnt     <= '0;
            grid_mode <= 2'b00;
        end else begin
            rd_vld  <= req && gnt;
            // all DIM words of a step staged, fire one enable
            base_en <= rd_vld && (rd_idx == IDX_W'(DIM - 1));
            // done trails the last enable by one cycle
            fin_sr  <= {fin_sr[1:0], req && gnt && last_word && last_step};
            if (start && !busy) begin
                busy      <= 1'b1;
                rd_act    <= 1'b1;
                w_cnt     <= '0;
                k_cnt     <= '0;
                grid_mode <= mode;
            end else if (fin_sr[2]) begin
                busy <= 1'b0;
            end
            if (rd_act && gnt) begin
                if (last_word) begin
                    w_cnt <= '0;
                    if (last_step)
                        rd_act <= 1'b0;
                    else
                        k_cnt <= k_cnt + 1'b1;
                end else begin
                    w_cnt <= w_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_idx <= w_cnt;
        if (rd_vld) begin
            h_stg[rd_idx] <= word.opnd.h_elem;
            v_stg[rd_idx] <= word.opnd.v_elem;
        end
    end

    // lane i carries row i and column i, both delayed by i cycles
    for (genvar i = 0; i < DIM; i++) begin : g_lane
        logic [LANE_W-1:0] lane_in;
        logic [LANE_W-1:0] lane_out;

        assign lane_in = {fin_sr[2], base_en, v_stg[i], h_stg[i]};

        if (i == 0) begin : g_direct
            assign lane_out = lane_in;
        end else begin : g_delay
            logic [LANE_W-1:0] sr [i];

            always_ff @(posedge clk) begin
                if (sys_rst) begin
                    for (int n = 0; n < i; n++)
                        sr[n] <= '0;
                end else begin
                    sr[0] <= lane_in;
                    for (int n = 1; n < i; n++)
                        sr[n] <= sr[n-1];
                end
            end
            assign lane_out = sr[i-1];
        end

        assign col_done[i]                 = lane_out[LANE_W-1];
        assign col_en[i]                   = lane_out[LANE_W-2];
        assign col_data[i*DATA_W +: DATA_W] = lane_out[DATA_W +: DATA_W];
        assign row_data[i*DATA_W +: DATA_W] = lane_out[0 +: DATA_W];
    end

    a_start_idle: assert property (
        @(posedge clk) disable iff (sys_rst) start |-> !busy
    ) else $error("start issued while the engine is busy");

endmodule

/* logic/result_drain.sv */
// result collection and write-back
`timescale 1ns/100ps

module result_drain import sa_pkg::*; #(
    parameter int DIM = 4
) (
    input  logic                  clk,
    input  logic                  sys_rst,
    input  logic                  start,
    input  logic [DIM-1:0]        row_res_val,
    input  logic [DIM*DATA_W-1:0] row_res,
    input  logic                  gnt,
    output logic                  req,
    output logic                  we,
    output logic [ADDR_W-1:0]     addr,
    output logic [WORD_W-1:0]     wr_data,
    output logic                  done
);

    localparam int NRES  = DIM * DIM;
    localparam int IDX_W = $clog2(NRES);
    localparam int COL_W = (DIM > 1) ? $clog2(DIM) : 1;

    sa_word_u          word;
    logic [COL_W-1:0]  col_cnt [DIM];
    logic [NRES-1:0]   filled;
    logic [DATA_W-1:0] res_buf [NRES];
    logic [IDX_W-1:0]  w_idx;

    // results leave in flat order i*DIM+j
    assign req  = filled[w_idx] && !done;
    assign we   = req;
    assign addr = RES_BASE + ADDR_W'(w_idx);

    always_comb begin
        word.res.tag   = DATA_W'(w_idx);
        word.res.value = res_buf[w_idx];
    end
    assign wr_data = word;

    always_ff @(posedge clk) begin
        if (sys_rst || start) begin
            filled <= '0;
            w_idx  <= '0;
            done   <= 1'b0;
            for (int i = 0; i < DIM; i++)
                col_cnt[i] <= '0;
        end else begin
            for (int i = 0; i < DIM; i++) begin
                if (row_res_val[i]) begin
                    filled[i*DIM + col_cnt[i]] <= 1'b1;
                    col_cnt[i] <= col_cnt[i] + 1'b1;
                end
            end
            if (req && gnt) begin
                w_idx <= w_idx + 1'b1;
                if (w_idx == IDX_W'(NRES - 1))
                    done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DIM; i++) begin
            if (row_res_val[i])
                res_buf[i*DIM + col_cnt[i]] <= row_res[i*DATA_W +: DATA_W];
        end
    end

endmodule

/* logic/tile_store.sv */
// shared tile store with fixed-priority arbiter
`timescale 1ns/100ps

module tile_store import sa_pkg::*; (
    input  logic              clk,
    input  logic              sys_rst,
    input  logic              drain_req,
    input  logic              drain_we,
    input  logic [ADDR_W-1:0] drain_addr,
    input  logic [WORD_W-1:0] drain_wdata,
    input  logic              feed_req,
    input  logic              feed_we,
    input  logic [ADDR_W-1:0] feed_addr,
    input  logic [WORD_W-1:0] feed_wdata,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [ADDR_W-1:0] host_addr,
    input  logic [WORD_W-1:0] host_wdata,
    output logic              drain_gnt,
    output logic              feed_gnt,
    output logic              host_gnt,
    output logic [WORD_W-1:0] rdata
);

    logic [WORD_W-1:0] mem [2**ADDR_W];
    logic              sel_we;
    logic [ADDR_W-1:0] sel_addr;
    logic [WORD_W-1:0] sel_wdata;

    // drain first, then feeder, host last
    assign drain_gnt = drain_req;
    assign feed_gnt  = feed_req && !drain_req;
    assign host_gnt  = host_req && !drain_req && !feed_req;

    always_comb begin
        if (drain_req) begin
            sel_we    = drain_we;
            sel_addr  = drain_addr;
            sel_wdata = drain_wdata;
        end else if (feed_req) begin
            sel_we    = feed_we;
            sel_addr  = feed_addr;
            sel_wdata = feed_wdata;
        end else begin
            sel_we    = host_req && host_we;
            sel_addr  = host_addr;
            sel_wdata = host_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_we)
            mem[sel_addr] <= sel_wdata;
        rdata <= mem[sel_addr];
    end

    // a waiting requester keeps asking until served
    a_feed_held: assert property (
        @(posedge clk) disable iff (sys_rst) feed_req && !feed_gnt |=> feed_req
    ) else $error("feeder dropped its request before the grant");

    a_host_held: assert property (
        @(posedge clk) disable iff (sys_rst) host_req && !host_gnt |=> host_req
    ) else $error("host dropped its request before the grant");

endmodule

/* logic/axil_regs.sv */
// AXI4-Lite register block and store window
`timescale 1ns/100ps

module axil_regs import sa_pkg::*; (
    input  logic              clk,
    input  logic              sys_rst,
    input  logic [AXI_AW-1:0] axil_awaddr,
    input  logic              axil_awvalid,
    output logic              axil_awready,
    input  logic [31:0]       axil_wdata,
    input  logic              axil_wvalid,
    output logic              axil_wready,
    output logic [1:0]        axil_bresp,
    output logic              axil_bvalid,
    input  logic              axil_bready,
    input  logic [AXI_AW-1:0] axil_araddr,
    input  logic              axil_arvalid,
    output logic              axil_arready,
    output logic [31:0]       axil_rdata,
    output logic [1:0]        axil_rresp,
    output logic              axil_rvalid,
    input  logic              axil_rready,
    input  logic              busy,
    input  logic              done,
    input  logic              host_gnt,
    input  logic [WORD_W-1:0] rdata,
    output logic              start,
    output logic [1:0]        mode,
    output logic [KLEN_W-1:0] k_len,
    output logic              host_req,
    output logic              host_we,
    output logic [ADDR_W-1:0] host_addr,
    output logic [WORD_W-1:0] host_wdata
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_sel, wr_win, wr_ok, wr_take;
    logic        rd_sel, rd_win, rd_ok, rd_take;
    logic        rd_wait;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [31:0] reg_rdata;

    // window is the aligned 1 KB block starting at WIN_BASE
    assign wr_win = axil_awaddr[AXI_AW-1:ADDR_W+2] == WIN_BASE[AXI_AW-1:ADDR_W+2];
    assign rd_win = axil_araddr[AXI_AW-1:ADDR_W+2] == WIN_BASE[AXI_AW-1:ADDR_W+2];
    assign wr_ok  = wr_win || axil_awaddr == REG_CTRL || axil_awaddr == REG_STATUS
                    || axil_awaddr == REG_KLEN;
    assign rd_ok  = rd_win || axil_araddr == REG_CTRL || axil_araddr == REG_STATUS
                    || axil_araddr == REG_KLEN;

    // write wins when both channels are pending
    assign wr_sel = axil_awvalid && axil_wvalid && !axil_bvalid;
    assign rd_sel = axil_arvalid && !axil_rvalid && !wr_sel;

    assign host_req   = (wr_sel && wr_win) || (rd_sel && rd_win);
    assign host_we    = wr_sel;
    assign host_addr  = wr_sel ? axil_awaddr[ADDR_W+1:2] : axil_araddr[ADDR_W+1:2];
    assign host_wdata = axil_wdata;

    // window accesses stall until the store grants
    assign wr_take      = wr_sel && (!wr_win || host_gnt);
    assign rd_take      = rd_sel && (!rd_win || host_gnt);
    assign axil_awready = wr_take;
    assign axil_wready  = wr_take;
    assign axil_arready = rd_take;

    always_comb begin
        case (axil_araddr)
            REG_CTRL:   reg_rdata = {29'd0, mode, 1'b0};
            REG_STATUS: reg_rdata = {30'd0, done, busy};
            REG_KLEN:   reg_rdata = {{(32-KLEN_W){1'b0}}, k_len};
            default:    reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            start       <= 1'b0;
            mode        <= 2'b00;
            k_len       <= KLEN_W'(1);
            axil_bvalid <= 1'b0;
            axil_bresp  <= RESP_OKAY;
            axil_rresp  <= RESP_OKAY;
            rvalid_q    <= 1'b0;
            rd_wait     <= 1'b0;
        end else begin
            start <= wr_take && axil_awaddr == REG_CTRL && axil_wdata[0];
            if (wr_take) begin
                axil_bvalid <= 1'b1;
                axil_bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                if (axil_awaddr == REG_CTRL)
                    mode <= axil_wdata[2:1];
                if (axil_awaddr == REG_KLEN)
                    k_len <= axil_wdata[KLEN_W-1:0];
            end else if (axil_bready) begin
                axil_bvalid <= 1'b0;
            end
            // store data shows for one cycle and is held if not taken
            rd_wait <= rd_take && rd_win;
            if (rd_take) begin
                axil_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
                rvalid_q   <= !rd_win;
            end else if (rd_wait) begin
                rvalid_q <= !axil_rready;
            end else if (axil_rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take && !rd_win)
            rdata_q <= reg_rdata;
        else if (rd_wait)
            rdata_q <= rdata;
    end

    assign axil_rvalid = rvalid_q || rd_wait;
    assign axil_rdata  = rd_wait ? rdata : rdata_q;

endmodule

/* logic/sa_top.sv */
// systolic matrix-multiply engine top
`timescale 1ns/100ps

module sa_top import sa_pkg::*; #(
    parameter int DIM = 4
) (
    input  logic              clk,
    input  logic              sys_rst,
    input  logic [AXI_AW-1:0] axil_awaddr,
    input  logic              axil_awvalid,
    output logic              axil_awready,
    input  logic [31:0]       axil_wdata,
    input  logic              axil_wvalid,
    output logic              axil_wready,
    output logic [1:0]        axil_bresp,
    output logic              axil_bvalid,
    input  logic              axil_bready,
    input  logic [AXI_AW-1:0] axil_araddr,
    input  logic              axil_arvalid,
    output logic              axil_arready,
    output logic [31:0]       axil_rdata,
    output logic [1:0]        axil_rresp,
    output logic              axil_rvalid,
    input  logic              axil_rready
);

    logic                  start, busy, done;
    logic [1:0]            mode, grid_mode;
    logic [KLEN_W-1:0]     k_len;
    logic                  host_req, host_we, host_gnt;
    logic [ADDR_W-1:0]     host_addr;
    logic [WORD_W-1:0]     host_wdata, rdata;
    logic                  feed_req, feed_gnt;
    logic [ADDR_W-1:0]     feed_addr;
    logic                  drain_req, drain_we, drain_gnt;
    logic [ADDR_W-1:0]     drain_addr;
    logic [WORD_W-1:0]     drain_wdata;
    logic [DIM-1:0]        col_en, col_done, row_res_val;
    logic [DIM*DATA_W-1:0] col_data, row_data, row_res;

    axil_regs i_regs (
        .clk, .sys_rst,
        .axil_awaddr, .axil_awvalid, .axil_awready,
        .axil_wdata, .axil_wvalid, .axil_wready,
        .axil_bresp, .axil_bvalid, .axil_bready,
        .axil_araddr, .axil_arvalid, .axil_arready,
        .axil_rdata, .axil_rresp, .axil_rvalid, .axil_rready,
        .busy, .done, .host_gnt, .rdata,
        .start, .mode, .k_len, .host_req, .host_we, .host_addr, .host_wdata
    );

    tile_store i_store (
        .clk, .sys_rst,
        .drain_req, .drain_we, .drain_addr, .drain_wdata,
        .feed_req, .feed_we (1'b0), .feed_addr, .feed_wdata ('0),
        .host_req, .host_we, .host_addr, .host_wdata,
        .drain_gnt, .feed_gnt, .host_gnt, .rdata
    );

    operand_feeder #(.DIM(DIM)) i_feeder (
        .clk, .sys_rst, .start, .mode, .k_len,
        .gnt (feed_gnt), .rd_data (rdata), .req (feed_req), .addr (feed_addr),
        .busy, .grid_mode, .col_en, .col_done, .col_data, .row_data
    );

    sa_grid #(.DIM(DIM)) i_grid (
        .clk, .sys_rst, .mode (grid_mode), .col_en, .col_done,
        .col_data, .row_data, .row_res_val, .row_res
    );

    result_drain #(.DIM(DIM)) i_drain (
        .clk, .sys_rst, .start, .row_res_val, .row_res,
        .gnt (drain_gnt), .req (drain_req), .we (drain_we),
        .addr (drain_addr), .wr_data (drain_wdata), .done
    );

endmodule

/* bench/tb_sa.sv */
// systolic array testbench
`timescale 1ns/100ps

module tb_sa import sa_pkg::*; ();

    localparam int DIM        = 4;
    localparam int GOLD_WORDS = 111;
    localparam int AXI_CYC    = 10;
    localparam logic [1:0] RESP_OK  = 2'b00;
    localparam logic [1:0] RESP_ERR = 2'b10;
    // word 100 of the store, clear of operands and results
    localparam logic [AXI_AW-1:0] SCRATCH = WIN_BASE + 12'h190;
    localparam logic [AXI_AW-1:0] RES_WIN = WIN_BASE + {RES_BASE, 2'b00};

    logic              clk;
    logic              sys_rst;
    logic [AXI_AW-1:0] axil_awaddr;
    logic              axil_awvalid;
    logic              axil_awready;
    logic [31:0]       axil_wdata;
    logic              axil_wvalid;
    logic              axil_wready;
    logic [1:0]        axil_bresp;
    logic              axil_bvalid;
    logic              axil_bready;
    logic [AXI_AW-1:0] axil_araddr;
    logic              axil_arvalid;
    logic              axil_arready;
    logic [31:0]       axil_rdata;
    logic [1:0]        axil_rresp;
    logic              axil_rvalid;
    logic              axil_rready;

    logic [15:0] gold [GOLD_WORDS];
    int          ptr;
    int          wd_cycles = 0;

    sa_top #(.DIM(DIM)) i_sa_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        fail_run($sformatf("timeout: no end of test after %0d cycles", wd_cycles));
    end

    task automatic write_word(input logic [AXI_AW-1:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
        @(posedge clk);
        axil_awaddr  <= addr;
        axil_wdata   <= data;
        axil_awvalid <= 1'b1;
        axil_wvalid  <= 1'b1;
        @(negedge clk);
        while (!axil_awready)
            @(negedge clk);
        // AW and W are taken together
        check_value("axil_wready", {31'd0, axil_wready}, 32'd1);
        @(posedge clk);
        axil_awvalid <= 1'b0;
        axil_wvalid  <= 1'b0;
        @(negedge clk);
        while (!axil_bvalid)
            @(negedge clk);
        if (axil_bresp !== exp_resp)
            fail_run($sformatf("write to %h answered with response %b instead of %b",
                               addr, axil_bresp, exp_resp));
        @(posedge clk);
    endtask

    task automatic read_word(input logic [AXI_AW-1:0] addr, input logic [1:0] exp_resp,
                             output logic [31:0] data);
        @(posedge clk);
        axil_araddr  <= addr;
        axil_arvalid <= 1'b1;
        @(negedge clk);
        while (!axil_arready)
            @(negedge clk);
        @(posedge clk);
        axil_arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rvalid)
            @(negedge clk);
        data = axil_rdata;
        if (axil_rresp !== exp_resp)
            fail_run($sformatf("read of %h answered with response %b instead of %b",
                               addr, axil_rresp, exp_resp));
        @(posedge clk);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[1])
            read_word(REG_STATUS, RESP_OK, st);
    endtask

    // load one golden record, start it, poke the window and check C
    task automatic run_matrix(input int run);
        logic [31:0] got;
        logic [1:0]  mode;
        int          k;
        int          a_at;
        int          b_at;
        int          c_at;
        mode = gold[ptr][1:0];
        k    = int'(gold[ptr + 1]);
        a_at = ptr + 2;
        b_at = a_at + DIM * k;
        c_at = b_at + k * DIM;
        ptr  = c_at + DIM * DIM;
        // word s*DIM+i pairs A[i][s] with B[s][i]
        for (int s = 0; s < k; s++)
            for (int i = 0; i < DIM; i++)
                write_word(WIN_BASE + AXI_AW'(4 * (s * DIM + i)),
                           {gold[a_at + i * k + s], gold[b_at + s * DIM + i]}, RESP_OK);
        write_word(REG_KLEN, 32'(k), RESP_OK);
        write_word(REG_CTRL, {29'd0, mode, 1'b1}, RESP_OK);
        // host traffic while the feeder owns the store
        write_word(SCRATCH, {16'(run), 16'hbeef}, RESP_OK);
        read_word(SCRATCH, RESP_OK, got);
        check_value("scratch word", got, {16'(run), 16'hbeef});
        wait_done();
        for (int idx = 0; idx < DIM * DIM; idx++) begin
            read_word(RES_WIN + AXI_AW'(4 * idx), RESP_OK, got);
            check_value($sformatf("result[%0d]", idx), got, {16'(idx), gold[c_at + idx]});
        end
    endtask

    initial begin
        logic [31:0] got;
        int          runs;
        int          walk;
        int          k;
        int          budget;
        sys_rst      = 1'b1;
        axil_awaddr  = '0;
        axil_awvalid = 1'b0;
        axil_wdata   = '0;
        axil_wvalid  = 1'b0;
        axil_bready  = 1'b1;
        axil_araddr  = '0;
        axil_arvalid = 1'b0;
        axil_rready  = 1'b1;
        $readmemh("bench/sa_golden.txt", gold);
        runs = int'(gold[0]);
        if (runs == 0)
            fail_run("golden file holds no runs");
        // watchdog budget from the run lengths and the bus traffic
        budget = 300;
        walk   = 1;
        for (int r = 0; r < runs; r++) begin
            k       = int'(gold[walk + 1]);
            budget += k + 2 * DIM + 40 + AXI_CYC * (DIM * k + DIM * DIM + 8);
            walk   += 2 + 2 * DIM * k + DIM * DIM;
        end
        wd_cycles = budget;
        ptr       = 1;

        repeat (2) @(posedge clk);
        sys_rst <= 1'b0;

        write_word(SCRATCH, 32'h1234_5678, RESP_OK);
        read_word(SCRATCH, RESP_OK, got);
        check_value("window word", got, 32'h1234_5678);
        write_word(REG_KLEN, 32'd9, RESP_OK);
        read_word(REG_KLEN, RESP_OK, got);
        check_value("k_len", got, 32'd9);
        write_word(REG_CTRL, 32'h6, RESP_OK);
        read_word(REG_CTRL, RESP_OK, got);
        check_value("ctrl mode", got, 32'h6);
        // holes in the map
        write_word(12'h100, 32'h0, RESP_ERR);
        read_word(12'h204, RESP_ERR, got);

        for (int r = 0; r < runs; r++)
            run_matrix(r);

        $display("TB PASSED");
        $finish;
    end

endmodule

/* bench/sa_golden.txt */
// per run: mode k_len / A row-major (4 x K) / B row-major (K x 4) / C row-major (4 x 4)
// 16-bit hex words, C wraps at 16 bits; the first word is the number of runs
0003
// run 1: mode 0, K 2
0000 0002
0001 0002 0003 0004 0005 0006 0007 0008
0001 0000 0002 0001 0000 0001 0001 0003
0001 0002 0004 0007 0003 0004 000a 000f 0005 0006 0010 0017 0007 0008 0016 001f
// run 2: mode 0, K 3
0000 0003
0002 0000 0001 0001 0001 0001 0000 0003 0002 0004 0001 0000
0001 0002 0003 0004 0005 0000 0001 0002 0002 0002 0000 0001
0004 0006 0006 0009 0008 0004 0004 0007 0013 0004 0003 0008 0009 0008 000d 0012
// run 3: mode 2, K 2, products that wrap
0002 0002
0100 0001 ffff 0002 0010 0010 0003 0000
0100 0001 0002 8000 0005 ffff 0007 0002
0005 00ff 0207 0002 ff0a fffd 000c 8004 1050 0000 0090 0020 0300 0003 0006 8000

/* sources.f */
common/sa_pkg.sv
pe_array/sa_pe.sv
pe_array/sa_grid.sv
logic/operand_feeder.sv
logic/result_drain.sv
logic/tile_store.sv
logic/axil_regs.sv
logic/sa_top.sv
bench/tb_sa.sv

/* run_sim.sh */
#!/bin/sh
# build and run the systolic array testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    -f sources.f --top-module tb_sa
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_sa > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
exit 0
